/* verilog.f */
logic/crPkg.sv
logic/crStageIf.sv
logic/crCmdQueue.sv
logic/crOperandRead.sv
logic/crExecute.sv
logic/crRegFile.sv
logic/crRetire.sv
logic/crPipeTop.sv
verification/crPipeChecker.sv
verification/crPipeTb.sv

/* Makefile */
LOG = sim.log

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module crPipeTb -f verilog.f --Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall --top-module crPipeTb -f verilog.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

/* verification/crPipeTb.sv */
// result credits return at random from a fixed seed; id 9 stands in for every unmapped id
`timescale 1ns/1ps

module crPipeTb;
	import crPkg::*;

	localparam int NumTests = 28;
	// per command budget plus reset and drain
	localparam int TimeoutCycles = 40 * NumTests + 100;

	logic clock;
	logic reset;
	logic cmdValid;
	crOp cmdOp;
	crId cmdId;
	logic [CrDataWidth-1:0] cmdOperand;
	logic cmdCredit;
	logic resultValid;
	logic [CrDataWidth-1:0] resultValue;
	logic resultCredit;
	int checkedCount;
	int errorCount;

	// stimulus table, expected value is the register before the command
	string testName [NumTests];
	crOp testOp [NumTests];
	crId testId [NumTests];
	logic [CrDataWidth-1:0] testOperand [NumTests];
	logic [CrDataWidth-1:0] testExpected [NumTests];
	int tableSize = 0;
	// issuer side
	int issued = 0;
	int cmdCreditsHeld = CmdCredits;
	// consumer side, credits still owed to the unit
	int resultsReceived = 0;
	int resultsOwed = 0;

	crPipeTop UUT (
		.clock(clock),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdId(cmdId),
		.cmdOperand(cmdOperand),
		.cmdCredit(cmdCredit),
		.resultValid(resultValid),
		.resultValue(resultValue),
		.resultCredit(resultCredit)
	);

	crPipeChecker resultCheck (
		.clock(clock),
		.reset(reset),
		.resultValid(resultValid),
		.resultValue(resultValue),
		.resultCredit(resultCredit),
		.checkedCount(checkedCount),
		.errorCount(errorCount)
	);

	// 40 ns period
	always #20 clock = ~clock;

	task automatic addTest(input string name, input crOp op, input crId id,
		input logic [CrDataWidth-1:0] operand, input logic [CrDataWidth-1:0] expected);
		testName[tableSize] = name;
		testOp[tableSize] = op;
		testId[tableSize] = id;
		testOperand[tableSize] = operand;
		testExpected[tableSize] = expected;
		tableSize++;
	endtask

	task automatic fillTable();
		// reset values
		addTest("srReset", opRead, idSr, '0, 64'h0000_0000_4000_0000);
		addTest("lrReset", opRead, idLr, '0, '0);
		// width masking
		addTest("spcWriteOnes", opWrite, idSpc, '1, '0);
		addTest("spcMasked", opRead, idSpc, '0, 64'h0000_ffff_ffff_ffff);
		addTest("lrWriteOnes", opWrite, idLr, '1, '0);
		addTest("lrFull", opRead, idLr, '0, 64'hffff_ffff_ffff_ffff);
		// FPSR rides in the top of GBR
		addTest("gbrWrite", opWrite, idGbr, 64'h1234_5678_9abc_def0, '0);
		addTest("gbrPacked", opRead, idGbr, '0, 64'h1234_5678_9abc_def0);
		// read-modify-write chain, each sees the one before
		addTest("exsrWrite", opWrite, idExsr, 64'h0000_0000_0000_00f0, '0);
		addTest("exsrSet", opSet, idExsr, 64'h0f00_0000_0000_0f00, 64'h0000_0000_0000_00f0);
		addTest("exsrClear", opClear, idExsr, 64'h0f00_0000_0000_0030, 64'h0f00_0000_0000_0ff0);
		addTest("exsrRead", opRead, idExsr, '0, 64'h0000_0000_0000_0fc0);
		// forwarded value must be trimmed to 48 bits
		addTest("sspSet", opSet, idSsp, 64'hffff_0000_0000_1111, '0);
		addTest("sspClear", opClear, idSsp, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_1111);
		addTest("sspRead", opRead, idSsp, '0, 64'h0000_0000_0000_1110);
		// zero register and unmapped ids
		addTest("zzrWrite", opWrite, idZzr, '1, '0);
		addTest("zzrRead", opRead, idZzr, '0, '0);
		addTest("unmappedWrite", opWrite, crId'(4'd9), '1, '0);
		addTest("unmappedRead", opRead, crId'(4'd9), '0, '0);
		// mapped registers untouched by those writes
		addTest("srAfter", opRead, idSr, '0, 64'h0000_0000_4000_0000);
		addTest("lrAfter", opRead, idLr, '0, 64'hffff_ffff_ffff_ffff);
		addTest("spcAfter", opRead, idSpc, '0, 64'h0000_ffff_ffff_ffff);
		addTest("gbrAfter", opRead, idGbr, '0, 64'h1234_5678_9abc_def0);
		addTest("exsrAfter", opRead, idExsr, '0, 64'h0000_0000_0000_0fc0);
		addTest("sspAfter", opRead, idSsp, '0, 64'h0000_0000_0000_1110);
		addTest("vbrAfter", opRead, idVbr, '0, '0);
		addTest("tbrAfter", opRead, idTbr, '0, '0);
		addTest("teaAfter", opRead, idTea, '0, '0);
	endtask

	// credits back first, then the next command if one is held
	task automatic driveCommand();
		if (cmdCredit)
			cmdCreditsHeld++;
		if (issued < NumTests && cmdCreditsHeld > 0)
		begin
			cmdValid = 1'b1;
			cmdOp = testOp[issued];
			cmdId = testId[issued];
			cmdOperand = testOperand[issued];
			issued++;
			cmdCreditsHeld--;
		end
		else
			cmdValid = 1'b0;
	endtask

	// count the result, then maybe hand one credit back
	task automatic returnCredit();
		if (resultValid)
		begin
			resultsReceived++;
			resultsOwed++;
		end
		resultCredit = 1'b0;
		// withheld three cycles in four on average
		if (resultsOwed > 0 && ($urandom % 4) == 0)
		begin
			resultCredit = 1'b1;
			resultsOwed--;
		end
	endtask

	initial
	begin
		int idx;
		void'($urandom(32'h5088));
		clock = 1'b0;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmdOp = opRead;
		cmdId = idZzr;
		cmdOperand = '0;
		resultCredit = 1'b0;
		fillTable();
		for (idx = 0; idx < NumTests; idx++)
			resultCheck.expectResult(testName[idx], testExpected[idx]);
		// two rising edges in reset
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (resultsReceived < NumTests)
		begin
			@(negedge clock);
			returnCredit();
			driveCommand();
		end
		resultCredit = 1'b0;
		// let the checker settle
		repeat (2) @(negedge clock);
		// every dequeued command hands its credit back
		if (cmdCreditsHeld != CmdCredits)
			$display("issuer holds %0d command credits at the end, expected %0d",
				cmdCreditsHeld, CmdCredits);
		$display("%0d of %0d tests checked, %0d errors", checkedCount, NumTests, errorCount);
		if (errorCount == 0 && checkedCount == NumTests && cmdCreditsHeld == CmdCredits)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (TimeoutCycles) @(posedge clock);
		$display("timeout after %0d cycles with %0d of %0d results received",
			TimeoutCycles, resultsReceived, NumTests);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verification/crPipeChecker.sv */
// results must come back in issue order; expectations are queued by the testbench before any command is sent
`timescale 1ns/1ps

module crPipeChecker (
	input logic clock,
	input logic reset,
	input logic resultValid,
	input logic [crPkg::CrDataWidth-1:0] resultValue,
	input logic resultCredit,
	output int checkedCount,
	output int errorCount
);
	import crPkg::*;

	// expected results in issue order
	string nameQueue [$];
	logic [CrDataWidth-1:0] valueQueue [$];
	// credit traffic seen at the pins
	int creditsReturned = 0;
	int resultsSeen = 0;
	// credits the unit held just before the latest rising edge
	int creditsHeld = ResultCredits;
	string name;
	logic [CrDataWidth-1:0] expected;

	initial
	begin
		checkedCount = 0;
		errorCount = 0;
	end

	// one entry per table row, same order as issue
	task automatic expectResult(input string testName, input logic [CrDataWidth-1:0] value);
		nameQueue.push_back(testName);
		valueQueue.push_back(value);
	endtask

	// credits are driven on the falling edge, stable here
	always @(posedge clock)
	begin
		if (!reset)
		begin
			// a credit returned on this edge is not usable until the next
			creditsHeld = ResultCredits + creditsReturned - resultsSeen;
			if (resultCredit)
				creditsReturned++;
		end
	end

	// results settle after the rising edge
	always @(negedge clock)
	begin
		if (!reset && resultValid)
		begin
			// unit must have held a credit on the edge that sent this result
			if (creditsHeld <= 0)
			begin
				$display("result sent at %0t while the unit held no result credit", $time);
				errorCount++;
			end
			resultsSeen++;
			if (valueQueue.size() == 0)
			begin
				$display("result %h arrived with no command outstanding", resultValue);
				errorCount++;
			end
			else
			begin
				name = nameQueue.pop_front();
				expected = valueQueue.pop_front();
				if (resultValue !== expected)
				begin
					$display("Mismatch %s: expected %h, actual %h", name, expected, resultValue);
					errorCount++;
				end
				else
					$display("%s ok, result %h", name, resultValue);
				checkedCount++;
			end
		end
	end

endmodule

/* logic/crPipeTop.sv */
// issuer starts with CmdCredits credits; unit starts with ResultCredits result credits
`timescale 1ns/1ps

module crPipeTop (
	input logic clock,
	input logic reset,
	input logic cmdValid,
	input crPkg::crOp cmdOp,
	input crPkg::crId cmdId,
	input logic [crPkg::CrDataWidth-1:0] cmdOperand,
	output logic cmdCredit,
	output logic resultValid,
	output logic [crPkg::CrDataWidth-1:0] resultValue,
	input logic resultCredit
);
	import crPkg::*;

	// stage handoffs
	crStageIf issueToEx1 ();
	crStageIf ex1ToEx2 ();
	crStageIf ex2ToEx3 ();

	// back-pressure from EX3
	logic stall;
	// register file ports
	crId readId;
	logic [CrDataWidth-1:0] readValue;
	logic writeEnable;
	crId writeId;
	logic [CrDataWidth-1:0] writeValue;

	crCmdQueue #(.QueueDepth(CmdCredits)) cmdQueue (
		.clock(clock),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdId(cmdId),
		.cmdOperand(cmdOperand),
		.cmdCredit(cmdCredit),
		.stall(stall),
		.out(issueToEx1.source)
	);

	// EX1 forwards from the EX2 and EX3 registers
	crOperandRead operandRead (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.in(issueToEx1.sink),
		.ex2Fwd(ex1ToEx2.sink),
		.ex3Fwd(ex2ToEx3.sink),
		.readId(readId),
		.readValue(readValue),
		.out(ex1ToEx2.source)
	);

	crExecute execute (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.in(ex1ToEx2.sink),
		.out(ex2ToEx3.source)
	);

	crRetire #(.CreditCount(ResultCredits)) retire (
		.clock(clock),
		.reset(reset),
		.in(ex2ToEx3.sink),
		.resultCredit(resultCredit),
		.stall(stall),
		.writeEnable(writeEnable),
		.writeId(writeId),
		.writeValue(writeValue),
		.resultValid(resultValid),
		.resultValue(resultValue)
	);

	crRegFile regFile (
		.clock(clock),
		.reset(reset),
		.readId(readId),
		.readValue(readValue),
		.writeEnable(writeEnable),
		.writeId(writeId),
		.writeValue(writeValue)
	);

endmodule

/* logic/crRetire.sv */
// EX3; the consumer returns one resultCredit per result and never more than it was sent
`timescale 1ns/1ps

module crRetire #(
	parameter int CreditCount = crPkg::ResultCredits
) (
	input logic clock,
	input logic reset,
	crStageIf.sink in,
	input logic resultCredit,
	output logic stall,
	output logic writeEnable,
	output crPkg::crId writeId,
	output logic [crPkg::CrDataWidth-1:0] writeValue,
	output logic resultValid,
	output logic [crPkg::CrDataWidth-1:0] resultValue
);
	import crPkg::*;

	// credits the unit still holds
	logic [$clog2(CreditCount+1)-1:0] credits;
	logic send;

	// EX3 entry stays in the EX2 register until it can go
	assign send = in.valid && (credits != '0);
	// no credit for a waiting entry, freeze everything upstream
	assign stall = in.valid && (credits == '0);

	// register write lands on the edge that raises resultValid
	assign writeEnable = send && (in.stage.cmd.op != opRead);
	assign writeId = in.stage.cmd.id;
	assign writeValue = in.stage.newValue;

	// credit counter and result flag
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			credits <= ($clog2(CreditCount+1))'(CreditCount);
			resultValid <= 1'b0;
		end
		else
		begin
			case ({send, resultCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			resultValid <= send;
		end
	end

	// software sees the value before the update
	always_ff @(posedge clock)
	begin
		if (send)
			resultValue <= in.stage.oldValue;
	end

endmodule

/* logic/crRegFile.sv */
// SR resets to bit 30 only; 48-bit registers read zero-extended; ZZR and ids 9-14 read zero
`timescale 1ns/1ps

module crRegFile (
	input logic clock,
	input logic reset,
	input crPkg::crId readId,
	output logic [crPkg::CrDataWidth-1:0] readValue,
	input logic writeEnable,
	input crPkg::crId writeId,
	input logic [crPkg::CrDataWidth-1:0] writeValue
);
	import crPkg::*;

	// full width registers
	logic [CrDataWidth-1:0] sr;
	logic [CrDataWidth-1:0] exsr;
	logic [CrDataWidth-1:0] lr;
	logic [CrDataWidth-1:0] tea;
	// address width registers
	logic [CrAddrWidth-1:0] spc;
	logic [CrAddrWidth-1:0] ssp;
	logic [CrAddrWidth-1:0] vbr;
	logic [CrAddrWidth-1:0] gbr;
	logic [CrAddrWidth-1:0] tbr;
	// lives above GBR
	logic [CrDataWidth-CrAddrWidth-1:0] fpsr;

	// read port
	always_comb
	begin
		case (readId)
			idSr: readValue = sr;
			idExsr: readValue = exsr;
			idLr: readValue = lr;
			idTea: readValue = tea;
			idSpc: readValue = {{(CrDataWidth-CrAddrWidth){1'b0}}, spc};
			idSsp: readValue = {{(CrDataWidth-CrAddrWidth){1'b0}}, ssp};
			idVbr: readValue = {{(CrDataWidth-CrAddrWidth){1'b0}}, vbr};
			idTbr: readValue = {{(CrDataWidth-CrAddrWidth){1'b0}}, tbr};
			// FPSR packed on top
			idGbr: readValue = {fpsr, gbr};
			// ZZR and unmapped
			default: readValue = '0;
		endcase
	end

	// write port, commits when EX3 sends its result
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sr <= SrResetValue;
			exsr <= '0;
			lr <= '0;
			tea <= '0;
			spc <= '0;
			ssp <= '0;
			vbr <= '0;
			gbr <= '0;
			tbr <= '0;
			fpsr <= '0;
		end
		else if (writeEnable)
		begin
			case (writeId)
				idSr: sr <= writeValue;
				idExsr: exsr <= writeValue;
				idLr: lr <= writeValue;
				idTea: tea <= writeValue;
				// upper bits dropped
				idSpc: spc <= writeValue[CrAddrWidth-1:0];
				idSsp: ssp <= writeValue[CrAddrWidth-1:0];
				idVbr: vbr <= writeValue[CrAddrWidth-1:0];
				idTbr: tbr <= writeValue[CrAddrWidth-1:0];
				idGbr:
				begin
					// one write sets both fields
					gbr <= writeValue[CrAddrWidth-1:0];
					fpsr <= writeValue[CrDataWidth-1:CrAddrWidth];
				end
				// ZZR and unmapped ids drop the write
				default:
				begin
				end
			endcase
		end
	end

endmodule

/* logic/crExecute.sv */
// EX2; new value is left unmasked, the register file and forwarding trim it
`timescale 1ns/1ps

module crExecute (
	input logic clock,
	input logic reset,
	input logic stall,
	crStageIf.sink in,
	crStageIf.source out
);
	import crPkg::*;

	logic [CrDataWidth-1:0] newValue;

	// read keeps old, write takes operand, set ORs, clear masks off
	assign newValue = applyOp(in.stage.cmd.op, in.stage.oldValue, in.stage.cmd.operand);

	// EX2 to EX3 register, also tapped by EX1 for forwarding
	always_ff @(posedge clock)
	begin
		if (reset)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= in.valid;
		if (!stall)
		begin
			out.stage.cmd <= in.stage.cmd;
			// old value is what the command returns
			out.stage.oldValue <= in.stage.oldValue;
			out.stage.newValue <= newValue;
		end
	end

endmodule

/* logic/crOperandRead.sv */
// EX1; forwards only from EX2 and EX3, so older results must already be in the register file
`timescale 1ns/1ps

module crOperandRead (
	input logic clock,
	input logic reset,
	input logic stall,
	crStageIf.sink in,
	crStageIf.sink ex2Fwd,
	crStageIf.sink ex3Fwd,
	output crPkg::crId readId,
	input logic [crPkg::CrDataWidth-1:0] readValue,
	crStageIf.source out
);
	import crPkg::*;

	logic ex2Hit;
	logic ex3Hit;
	logic [CrDataWidth-1:0] ex2Pending;
	logic [CrDataWidth-1:0] oldValue;

	// register file read for the command sitting in EX1
	assign readId = in.stage.cmd.id;

	// only writing ops to the same id count as hazards
	assign ex2Hit = ex2Fwd.valid && (ex2Fwd.stage.cmd.id == in.stage.cmd.id)
		&& (ex2Fwd.stage.cmd.op != opRead);
	assign ex3Hit = ex3Fwd.valid && (ex3Fwd.stage.cmd.id == in.stage.cmd.id)
		&& (ex3Fwd.stage.cmd.op != opRead);

	// EX2 result is still being computed, so apply its op here
	assign ex2Pending = applyOp(ex2Fwd.stage.cmd.op, ex2Fwd.stage.oldValue,
		ex2Fwd.stage.cmd.operand);

	always_comb
	begin
		oldValue = readValue;
		// EX3 is older than EX2
		if (ex3Hit)
			oldValue = maskToWidth(in.stage.cmd.id, ex3Fwd.stage.newValue);
		// youngest writer wins
		if (ex2Hit)
			oldValue = maskToWidth(in.stage.cmd.id, ex2Pending);
	end

	// EX1 to EX2 register
	always_ff @(posedge clock)
	begin
		if (reset)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= in.valid;
		if (!stall)
		begin
			out.stage.cmd <= in.stage.cmd;
			out.stage.oldValue <= oldValue;
			// read result until EX2 applies the op
			out.stage.newValue <= oldValue;
		end
	end

endmodule

/* logic/crCmdQueue.sv */
// issuer must hold a credit for every cmdValid; no overflow detection
`timescale 1ns/1ps

module crCmdQueue #(
	parameter int QueueDepth = crPkg::CmdCredits
) (
	input logic clock,
	input logic reset,
	input logic cmdValid,
	input crPkg::crOp cmdOp,
	input crPkg::crId cmdId,
	input logic [crPkg::CrDataWidth-1:0] cmdOperand,
	output logic cmdCredit,
	input logic stall,
	crStageIf.source out
);
	import crPkg::*;

	// command storage
	crCmd mem [QueueDepth];
	logic [$clog2(QueueDepth)-1:0] wrPtr;
	logic [$clog2(QueueDepth)-1:0] rdPtr;
	logic [$clog2(QueueDepth+1)-1:0] count;
	logic push;
	logic pop;

	// credit rule guarantees room
	assign push = cmdValid;
	// entry written this cycle is not visible until the next
	assign pop = (count != '0) && !stall;

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wrPtr] <= '{op: cmdOp, id: cmdId, operand: cmdOperand};
	end

	// pointers and fill level
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			cmdCredit <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= (int'(wrPtr) == QueueDepth - 1) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (int'(rdPtr) == QueueDepth - 1) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per dequeue
			cmdCredit <= pop;
		end
	end

	// head register feeding EX1, frozen on stall
	always_ff @(posedge clock)
	begin
		if (reset)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= pop;
		if (pop)
		begin
			out.stage.cmd <= mem[rdPtr];
			// values are filled in by later stages
			out.stage.oldValue <= '0;
			out.stage.newValue <= '0;
		end
	end

endmodule

/* logic/crStageIf.sv */
// one pipeline stage handoff; payload is only meaningful while valid is high
`timescale 1ns/1ps

interface crStageIf;
	import crPkg::*;

	// entry present in this stage
	logic valid;
	// opcode, id, operand and both register values
	crStage stage;

	// upstream stage owns the register
	modport source (
		output valid,
		output stage
	);

	// downstream stage and forwarding taps
	modport sink (
		input valid,
		input stage
	);

endinterface

/* logic/crPkg.sv */
// shared ids, opcodes and stage payload; ids 9 to 14 are unmapped and behave like ZZR
package crPkg;

	// register widths
	localparam int CrDataWidth = 64;
	localparam int CrAddrWidth = 48;

	// credit depths on the issue side and the result side
	localparam int CmdCredits = 4;
	localparam int ResultCredits = 4;

	// SR comes up with only bit 30 set
	localparam logic [CrDataWidth-1:0] SrResetValue = 64'h0000_0000_4000_0000;

	// control register ids
	typedef enum logic [3:0] {
		idSr = 4'd0,
		idExsr = 4'd1,
		idLr = 4'd2,
		idSpc = 4'd3,
		idSsp = 4'd4,
		idVbr = 4'd5,
		idGbr = 4'd6,
		idTbr = 4'd7,
		idTea = 4'd8,
		idZzr = 4'd15
	} crId;

	typedef enum logic [1:0] {
		opRead = 2'd0,
		opWrite = 2'd1,
		opSet = 2'd2,
		opClear = 2'd3
	} crOp;

	// command as issued, 70 bits
	typedef struct packed {
		crOp op;
		crId id;
		logic [CrDataWidth-1:0] operand;
	} crCmd;

	// payload carried by every stage, 198 bits
	typedef struct packed {
		crCmd cmd;
		logic [CrDataWidth-1:0] oldValue;
		logic [CrDataWidth-1:0] newValue;
	} crStage;

	// new register value for one command
	function automatic logic [CrDataWidth-1:0] applyOp(
		input crOp op,
		input logic [CrDataWidth-1:0] oldValue,
		input logic [CrDataWidth-1:0] operand
	);
		case (op)
			opWrite: applyOp = operand;
			opSet: applyOp = oldValue | operand;
			opClear: applyOp = oldValue & ~operand;
			default: applyOp = oldValue;
		endcase
	endfunction

	// value as the register file would return it after storing
	function automatic logic [CrDataWidth-1:0] maskToWidth(
		input crId id,
		input logic [CrDataWidth-1:0] value
	);
		case (id)
			// GBR keeps FPSR in its top 16 bits
			idSr, idExsr, idLr, idTea, idGbr: maskToWidth = value;
			idSpc, idSsp, idVbr, idTbr:
				maskToWidth = {{(CrDataWidth-CrAddrWidth){1'b0}}, value[CrAddrWidth-1:0]};
			default: maskToWidth = '0;
		endcase
	endfunction

endpackage
